//--- dv/tb_eth_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eth_rx import eth_pkg::*, csr_pkg::*; ();

    localparam int FRAME_COUNT = 14;                    // Frames sent over the whole run
    localparam int MAX_STROBES = 232;                   // Longest frame plus idle strobes
    localparam int WATCHDOG_NS = FRAME_COUNT * MAX_STROBES * 20 * 4;

    logic       clk = 1'b0;
    logic       reset_n;
    logic [7:0] rx_data;
    logic       rx_dv, rx_er, rx_rdy;
    eth_beat_t  m_beat;
    logic       m_valid, m_ready;
    axil_req_t  axil_req;
    axil_rsp_t  axil_rsp;

    logic [31:0] lcg_state = 32'he90f;
    logic [7:0]  frame_buf [256];                       // Payload of the frame being built
    logic [7:0]  exp_bytes [$];                         // Expected stream, all frames back to back
    int          exp_len [$];
    bit          exp_user [$];
    bit          exp_trunc [$];                         // Frame cut short by overflow
    int          beat_pos = 0;                          // Position inside the head frame
    int          beats = 0;
    int          errors = 0;
    logic        last_exp;
    int          tally_ok = 0, tally_crc = 0, tally_phy = 0, tally_ovf = 0;
    int          len;

    eth_rx_top u_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Reflected CRC-32 over frame_buf, bit by bit, complemented at the end
    function automatic logic [31:0] crc_ref(input int n);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            c = c ^ {24'h0, frame_buf[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus, driven on the falling edge
    //////////////////////////////////////////////////////////////////////
    task automatic send_byte(input logic [7:0] b, input logic dv, input logic er,
                             input bit gapped);
        logic [31:0] r;
        r = lcg_next();
        while (gapped && r[17:16] == 2'b00) begin       // Roughly one gap per three strobes
            rx_rdy = 1'b0;
            @(negedge clk);
            r = lcg_next();
        end
        rx_data = b;
        rx_dv   = dv;
        rx_er   = er;
        rx_rdy  = 1'b1;
        @(negedge clk);
        rx_rdy  = 1'b0;
    endtask

    task automatic fill_payload(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = lcg_next();
            frame_buf[i] = r[23:16];
        end
    endtask

    task automatic send_frame(input int n, input int pre_n, input bit gapped,
                              input bit bad_fcs, input int er_at);
        logic [31:0] fcs;
        fcs = crc_ref(n);
        if (bad_fcs) fcs[15:8] = ~fcs[15:8];            // Spoil the second FCS byte
        for (int i = 0; i < pre_n; i++) send_byte(8'h55, 1'b1, 1'b0, gapped);
        send_byte(8'hD5, 1'b1, 1'b0, gapped);
        for (int i = 0; i < n; i++) send_byte(frame_buf[i], 1'b1, i == er_at, gapped);
        for (int i = 0; i < 4; i++) send_byte(fcs[8*i +: 8], 1'b1, 1'b0, gapped);  // LSB first
        repeat (12) send_byte(8'h00, 1'b0, 1'b0, gapped);   // Inter-frame idle
    endtask

    task automatic expect_frame(input int n, input bit user, input bit trunc);
        for (int i = 0; i < n; i++) exp_bytes.push_back(frame_buf[i]);
        exp_len.push_back(n);
        exp_user.push_back(user);
        exp_trunc.push_back(trunc);
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_len.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_len.size() != 0) begin
            $display("Stream stalled at %0t with %0d frames still owed", $time, exp_len.size());
            errors++;
        end
        repeat (4) @(negedge clk);                      // Let counters settle
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite manager
    //////////////////////////////////////////////////////////////////////
    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int n;
        @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.arready && n < 50);
        if (n >= 50) begin
            $display("Read at 0x%h got no arready by %0t", addr, $time);
            errors++;
        end
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.rvalid && n < 50);         // Handshake with rready high
        data = axil_rsp.rdata;
        if (n >= 50) begin
            $display("Read at 0x%h got no rvalid by %0t", addr, $time);
            errors++;
        end else if (axil_rsp.rresp !== 2'b00) begin    // Always OKAY
            $display("FAIL %0t: read at 0x%h has rresp %b", $time, addr, axil_rsp.rresp);
            errors++;
        end
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        int n;
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.awready && n < 50);
        if (axil_rsp.awready && axil_rsp.wready !== 1'b1) begin   // AW and W accepted together
            $display("FAIL %0t: write at 0x%h has awready without wready", $time, addr);
            errors++;
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        do begin
            @(posedge clk);
            n++;
        end while (!axil_rsp.bvalid && n < 100);
        if (n >= 100) begin
            $display("Write at 0x%h never completed by %0t", addr, $time);
            errors++;
        end else if (axil_rsp.bresp !== 2'b00) begin
            $display("FAIL %0t: write at 0x%h has bresp %b", $time, addr, axil_rsp.bresp);
            errors++;
        end
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic check_count(input logic [3:0] addr, input int exp);
        logic [31:0] got;
        axil_read(addr, got);
        if (got !== 32'(exp)) begin
            $display("FAIL %0t: counter 0x%h reads %0d, expected %0d", $time, addr, got, exp);
            errors++;
        end
    endtask

    task automatic drop_front();
        exp_len.delete(0);
        exp_user.delete(0);
        exp_trunc.delete(0);
        beat_pos = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stream checker, one beat per accepted handshake
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (reset_n && m_valid && m_ready) begin
            beats++;
            if (exp_len.size() == 0) begin
                $display("FAIL %0t: beat 0x%h with no frame expected", $time, m_beat.data);
                errors++;
            end else if (exp_trunc[0] && m_beat.last) begin    // Closing beat after overflow
                if (m_beat.user !== 1'b1) begin
                    $display("FAIL %0t: overflow closing beat has user low", $time);
                    errors++;
                end
                repeat (exp_len[0] - beat_pos) void'(exp_bytes.pop_front());
                drop_front();
            end else begin
                last_exp = !exp_trunc[0] && (beat_pos == exp_len[0] - 1);
                if (m_beat.data !== exp_bytes[0]) begin
                    $display("FAIL %0t: byte %0d is 0x%h, expected 0x%h", $time, beat_pos,
                             m_beat.data, exp_bytes[0]);
                    errors++;
                end
                if (m_beat.last !== last_exp) begin
                    $display("FAIL %0t: last is %b at byte %0d", $time, m_beat.last, beat_pos);
                    errors++;
                end
                if (m_beat.user !== (last_exp & exp_user[0])) begin
                    $display("FAIL %0t: user is %b at byte %0d", $time, m_beat.user, beat_pos);
                    errors++;
                end
                void'(exp_bytes.pop_front());
                beat_pos++;
                if (last_exp) drop_front();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        reset_n  = 1'b0;
        rx_data  = 8'h00;
        rx_dv    = 1'b0;
        rx_er    = 1'b0;
        rx_rdy   = 1'b0;
        m_ready  = 1'b1;
        axil_req = '0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        repeat (4) @(negedge clk);

        for (int i = 0; i < 8; i++) begin               // Good frames, alternate gapped strobes
            len = 64 + int'(lcg_next() % 32'd137);
            fill_payload(len);
            expect_frame(len, 1'b0, 1'b0);
            send_frame(len, 7, (i % 2) == 1, 1'b0, -1);
            tally_ok++;
        end
        len = 90;                                       // Corrupted FCS
        fill_payload(len);
        expect_frame(len, 1'b1, 1'b0);
        send_frame(len, 7, 1'b1, 1'b1, -1);
        tally_crc++;
        len = 110;                                      // PHY error mid payload
        fill_payload(len);
        expect_frame(len, 1'b1, 1'b0);
        send_frame(len, 7, 1'b0, 1'b0, len / 2);
        tally_phy++;
        fill_payload(70);                               // Short preamble is ignored
        send_frame(70, 6, 1'b0, 1'b0, -1);
        wait_drain(2000);

        //////////////////////////////////////////////////////////////////
        // Overflow with the stream stalled
        //////////////////////////////////////////////////////////////////
        m_ready = 1'b0;
        len = 150;                                      // Longer than the FIFO
        fill_payload(len);
        expect_frame(len, 1'b1, 1'b1);
        send_frame(len, 7, 1'b0, 1'b0, -1);
        tally_ovf++;
        fill_payload(80);                               // Arrives while still full
        send_frame(80, 7, 1'b0, 1'b0, -1);
        tally_ovf++;
        m_ready = 1'b1;
        wait_drain(2000);
        len = 64;                                       // Recovery frame
        fill_payload(len);
        expect_frame(len, 1'b0, 1'b0);
        send_frame(len, 7, 1'b1, 1'b0, -1);
        tally_ok++;
        wait_drain(2000);

        check_count(REG_FRAMES_OK, tally_ok);
        check_count(REG_CRC_ERR, tally_crc);
        check_count(REG_PHY_ERR, tally_phy);
        check_count(REG_OVERFLOW, tally_ovf);
        axil_write(REG_FRAMES_OK, 32'h0);               // Clears all counters
        check_count(REG_FRAMES_OK, 0);
        check_count(REG_CRC_ERR, 0);
        check_count(REG_PHY_ERR, 0);
        check_count(REG_OVERFLOW, 0);

        $display("Beats checked %0d, errors %0d", beats, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
src/eth_pkg.sv
src/csr_pkg.sv
src/crc32.sv
src/rx_mac.sv
src/rx_frame_fifo.sv
src/rx_stats_csr.sv
src/eth_rx_top.sv
dv/tb_eth_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_eth_rx -f project.f -o sim_eth_rx \
    && ./obj_dir/sim_eth_rx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation finished without failures"; exit 0; }

//--- src/crc32.sv
`timescale 1ns/1ns
`default_nettype none

// Next CRC-32 state after one byte, LSB of the byte first
module crc32 import eth_pkg::*; (
    input  logic [31:0] crc_in,     // Current state
    input  logic [7:0]  data,       // Byte to fold in
    output logic [31:0] crc_out     // State after the byte
);

    logic [31:0] acc;

    //////////////////////////////////////////////////////////////////////
    // Bit-serial division, unrolled over the eight data bits
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        acc = crc_in ^ {24'h00_0000, data};    // Byte enters at the low end
        for (int i = 0; i < 8; i++) begin
            if (acc[0]) begin
                acc = (acc >> 1) ^ CRC_POLY;   // Shifted out a one
            end else begin
                acc = acc >> 1;
            end
        end
    end

    assign crc_out = acc;

endmodule

`default_nettype wire

//--- src/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Manager side of the AXI4-Lite port
    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Subordinate side of the AXI4-Lite port
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [1:0] AXI_OKAY = 2'b00;

    // Statistics register map, one 32-bit counter per word
    localparam logic [3:0] REG_FRAMES_OK = 4'h0;
    localparam logic [3:0] REG_CRC_ERR   = 4'h4;
    localparam logic [3:0] REG_PHY_ERR   = 4'h8;
    localparam logic [3:0] REG_OVERFLOW  = 4'hC;

endpackage

`default_nettype wire

//--- src/eth_pkg.sv
`default_nettype none

package eth_pkg;

    //////////////////////////////////////////////////////////////////////
    // Framing and CRC constants
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0]  ETH_PRE   = 8'h55;          // Preamble byte
    localparam logic [7:0]  ETH_SFD   = 8'hD5;          // Start frame delimiter
    localparam int unsigned PRE_COUNT = 7;              // Preamble bytes ahead of the SFD
    localparam logic [31:0] CRC_INIT  = 32'hFFFF_FFFF;  // CRC seed
    localparam logic [31:0] CRC_POLY  = 32'hEDB8_8320;  // Reflected form of 0x04C11DB7

    localparam int unsigned FIFO_DEPTH = 64;            // Beats held by the frame FIFO

    // One byte of the receive stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;   // Final byte of the frame
        logic       user;   // Frame is bad
    } eth_beat_t;

    // Single cycle pulses at frame end
    typedef struct packed {
        logic frame_ok;
        logic crc_err;
        logic phy_err;
        logic overflow;
    } rx_event_t;

endpackage

`default_nettype wire

//--- src/eth_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module eth_rx_top import eth_pkg::*, csr_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] rx_data,
    input  logic       rx_dv,
    input  logic       rx_er,
    input  logic       rx_rdy,
    output eth_beat_t  m_beat,      // Receive stream
    output logic       m_valid,
    input  logic       m_ready,
    input  axil_req_t  axil_req,    // Statistics port
    output axil_rsp_t  axil_rsp
);

    eth_beat_t wr_beat;             // MAC to FIFO
    logic      wr_en;
    logic      has_room;
    rx_event_t rx_event;            // MAC to statistics

    rx_mac u_rx_mac (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_data  (rx_data),
        .rx_dv    (rx_dv),
        .rx_er    (rx_er),
        .rx_rdy   (rx_rdy),
        .has_room (has_room),
        .wr_beat  (wr_beat),
        .wr_en    (wr_en),
        .rx_event (rx_event)
    );

    rx_frame_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_rx_frame_fifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .wr_beat  (wr_beat),
        .wr_en    (wr_en),
        .has_room (has_room),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready)
    );

    rx_stats_csr u_rx_stats_csr (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_event (rx_event),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

endmodule

`default_nettype wire

//--- src/rx_frame_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module rx_frame_fifo import eth_pkg::*; #(
    parameter int unsigned DEPTH = 16   // Storage slots, power of two
) (
    input  logic      clk,
    input  logic      reset_n,
    input  eth_beat_t wr_beat,
    input  logic      wr_en,
    output logic      has_room,
    output eth_beat_t m_beat,
    output logic      m_valid,
    input  logic      m_ready
);

    localparam int unsigned AW = $clog2(DEPTH);
    localparam int unsigned CW = $clog2(DEPTH + 1);

    eth_beat_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;           // Beats held in mem, output register excluded
    logic          load;            // Output register free this cycle
    logic          pop, push, bypass;

    assign load   = !m_valid || m_ready;
    assign pop    = load && (count != '0);
    assign bypass = load && (count == '0) && wr_en;       // Empty path straight to output
    assign push   = wr_en && !bypass && (count != CW'(DEPTH));

    // Counts the beat being written now so the MAC never overruns
    assign has_room = wr_en ? (count < CW'(DEPTH - 1)) : (count < CW'(DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_beat;
        end
        if (pop) begin
            m_beat <= mem[rd_ptr];
        end else if (bypass) begin
            m_beat <= wr_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            m_valid <= 1'b0;
        end else begin
            if (load) m_valid <= pop || bypass;
            if (push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(push) - CW'(pop);
        end
    end

endmodule

`default_nettype wire

//--- src/rx_mac.sv
`timescale 1ns/1ns
`default_nettype none

module rx_mac import eth_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] rx_data,     // De-skewed RGMII byte
    input  logic       rx_dv,
    input  logic       rx_er,
    input  logic       rx_rdy,      // Byte strobe
    input  logic       has_room,    // FIFO can take one more beat
    output eth_beat_t  wr_beat,
    output logic       wr_en,
    output rx_event_t  rx_event
);

    // One slot of the delay line
    typedef struct packed {
        logic [7:0] data;
        logic       dv;
        logic       er;
    } stage_t;

    typedef enum logic [1:0] {IDLE, PAYLOAD, DROP} state_t;

    stage_t      dly [5];           // dly[4] is the tail
    state_t      state, state_nxt;
    logic [3:0]  pre_cnt;           // Preamble bytes seen leaving the tail
    logic [31:0] crc_state, crc_next;
    logic        er_seen;           // Sticky PHY error for this frame
    logic        close_pend;        // Overflowed frame still owes a last beat
    logic        close_nxt;
    logic        wr_nxt;
    eth_beat_t   beat_nxt;
    rx_event_t   ev_nxt;
    logic        start;             // SFD at the tail after a full preamble
    logic        frame_end;         // First strobe with dv low
    logic [31:0] fcs_rx;
    logic        fcs_er;
    logic        phy_bad, crc_bad;

    crc32 u_crc32 (
        .crc_in  (crc_state),
        .data    (dly[4].data),
        .crc_out (crc_next)
    );

    assign start     = (state == IDLE) && rx_rdy && dly[4].dv
                       && (dly[4].data == ETH_SFD) && (pre_cnt == 4'(PRE_COUNT));
    assign frame_end = rx_rdy && !rx_dv;

    // FCS sits in the line LSB first, oldest byte nearest the tail
    assign fcs_rx  = {dly[0].data, dly[1].data, dly[2].data, dly[3].data};
    assign fcs_er  = dly[0].er | dly[1].er | dly[2].er | dly[3].er;
    assign phy_bad = er_seen | dly[4].er | fcs_er;
    assign crc_bad = (~crc_next != fcs_rx);    // Final data byte already folded in

    //////////////////////////////////////////////////////////////////////
    // Frame FSM and beat selection
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        close_nxt = close_pend;
        wr_nxt    = 1'b0;
        beat_nxt  = '{data: dly[4].data, last: 1'b0, user: 1'b0};
        ev_nxt    = '0;

        if (close_pend && has_room) begin          // Closing beat of an overflowed frame
            wr_nxt    = 1'b1;
            beat_nxt  = '{data: 8'h00, last: 1'b1, user: 1'b1};
            close_nxt = 1'b0;
        end

        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = has_room ? PAYLOAD : DROP;   // Reject when FIFO is full
                end
            end
            PAYLOAD: begin
                if (rx_rdy && !has_room) begin      // FIFO filled mid-frame
                    close_nxt       = 1'b1;
                    ev_nxt.overflow = frame_end;
                    state_nxt       = frame_end ? IDLE : DROP;
                end else if (rx_rdy) begin
                    wr_nxt = 1'b1;
                    if (frame_end) begin
                        beat_nxt.last   = 1'b1;
                        beat_nxt.user   = phy_bad | crc_bad;
                        ev_nxt.frame_ok = !(phy_bad | crc_bad);
                        ev_nxt.phy_err  = phy_bad;
                        ev_nxt.crc_err  = crc_bad & !phy_bad;   // PHY error wins
                        state_nxt       = IDLE;
                    end
                end
            end
            DROP: begin
                if (frame_end) begin                // Discard until the frame is over
                    ev_nxt.overflow = 1'b1;
                    state_nxt       = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Control state and delay line
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 5; i++) begin
                dly[i] <= '0;
            end
            state      <= IDLE;
            pre_cnt    <= '0;
            er_seen    <= 1'b0;
            close_pend <= 1'b0;
            wr_en      <= 1'b0;
            rx_event   <= '0;
        end else begin
            state      <= state_nxt;
            close_pend <= close_nxt;
            wr_en      <= wr_nxt;
            rx_event   <= ev_nxt;
            if (rx_rdy) begin
                for (int i = 4; i > 0; i--) begin
                    dly[i] <= dly[i-1];
                end
                dly[0] <= '{data: rx_data, dv: rx_dv, er: rx_er};
                if (dly[4].dv && dly[4].data == ETH_PRE) begin
                    if (pre_cnt != 4'(PRE_COUNT)) begin
                        pre_cnt <= pre_cnt + 1'b1;  // Saturates at the required count
                    end
                end else begin
                    pre_cnt <= '0;
                end
            end
            if (start) begin
                er_seen <= 1'b0;
            end else if (state == PAYLOAD && rx_rdy) begin
                er_seen <= er_seen | dly[4].er;
            end
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        wr_beat <= beat_nxt;
        if (start) begin
            crc_state <= CRC_INIT;
        end else if (state == PAYLOAD && rx_rdy) begin
            crc_state <= crc_next;                  // Fold the byte leaving the line
        end
    end

endmodule

`default_nettype wire

//--- src/rx_stats_csr.sv
`timescale 1ns/1ns
`default_nettype none

module rx_stats_csr import eth_pkg::*, csr_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  rx_event_t rx_event,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);

    logic [31:0] cnt [4];           // Indexed by address bits 3:2
    logic [3:0]  ev_vec;
    logic        aw_rdy;            // Drives both awready and wready
    logic        b_vld;
    logic        ar_rdy;
    logic        r_vld;
    logic [31:0] r_data;
    logic [31:0] rd_mux;
    logic        clear;             // AW and W handshake this cycle
    logic        ar_fire;

    assign ev_vec  = {rx_event.overflow, rx_event.phy_err, rx_event.crc_err,
                      rx_event.frame_ok};
    assign clear   = aw_rdy && axil_req.awvalid && axil_req.wvalid;
    assign ar_fire = ar_rdy && axil_req.arvalid;

    always_comb begin
        case ({axil_req.araddr[3:2], 2'b00})
            REG_FRAMES_OK: rd_mux = cnt[0];
            REG_CRC_ERR:   rd_mux = cnt[1];
            REG_PHY_ERR:   rd_mux = cnt[2];
            REG_OVERFLOW:  rd_mux = cnt[3];
            default:       rd_mux = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite handshakes and counters
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            aw_rdy <= 1'b0;
            b_vld  <= 1'b0;
            ar_rdy <= 1'b0;
            r_vld  <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            // Wait for AW and W together, then one ready cycle
            aw_rdy <= !aw_rdy && !b_vld && axil_req.awvalid && axil_req.wvalid;
            if (clear)                        b_vld <= 1'b1;
            else if (b_vld && axil_req.bready) b_vld <= 1'b0;

            ar_rdy <= !ar_rdy && !r_vld && axil_req.arvalid;
            if (ar_fire)                       r_vld <= 1'b1;
            else if (r_vld && axil_req.rready) r_vld <= 1'b0;

            for (int i = 0; i < 4; i++) begin
                if (clear) begin
                    cnt[i] <= '0;               // Any write clears every counter
                end else if (ev_vec[i] && cnt[i] != '1) begin
                    cnt[i] <= cnt[i] + 1'b1;    // Saturating
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) r_data <= rd_mux;          // Captured at the address handshake
    end

    assign axil_rsp = '{awready: aw_rdy, wready: aw_rdy, bvalid: b_vld, bresp: AXI_OKAY,
                        arready: ar_rdy, rvalid: r_vld, rdata: r_data, rresp: AXI_OKAY};

endmodule

`default_nettype wire
